// File: hw/ooo_core_pkg.sv
package ooo_core_pkg;

	localparam int XLEN = 32;
	localparam int REG_AW = 5;
	localparam int NREG = 32;
	localparam int OPC_W = 6;
	localparam int WIN_SLOTS = 3;

	// pc counts instructions and the pair address drops bit 0
	localparam int PC_W_DEFAULT = 14;

	// field positions as lsb and width
	localparam int OPC_LSB = 26;
	localparam int RD_LSB = 21;
	localparam int RS_LSB = 16;
	localparam int RT_LSB = 11;
	localparam int IMM_LSB = 0;
	localparam int IMM_W = 16;

	typedef enum logic [OPC_W-1:0] {
		OP_NOP = 6'd0,
		OP_ADD = 6'd1,
		OP_SUB = 6'd2,
		OP_AND = 6'd3,
		OP_OR = 6'd4,
		OP_XOR = 6'd5,
		OP_SLL = 6'd6,
		OP_SRL = 6'd7,
		OP_ADDI = 6'd8,
		OP_LUI = 6'd9
	} opcode_t;

endpackage

// File: hw/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
	import ooo_core_pkg::*;
(
	input  logic              clk,
	input  logic              rstn,
	input  logic              i_valid,
	input  opcode_t           i_opc,
	input  logic [XLEN-1:0]   i_a,
	input  logic [XLEN-1:0]   i_b,
	input  logic [IMM_W-1:0]  i_imm,
	input  logic [REG_AW-1:0] i_dest,
	output logic              o_wb_valid,
	output logic [REG_AW-1:0] o_wb_addr,
	output logic [XLEN-1:0]   o_wb_data
);

	localparam int SH_W = $clog2(XLEN);

	logic [XLEN-1:0] imm_sx;
	logic [XLEN-1:0] result;

	assign imm_sx = {{(XLEN-IMM_W){i_imm[IMM_W-1]}}, i_imm};

	always_comb begin
		case (i_opc)
			OP_ADD: result = i_a + i_b;
			OP_SUB: result = i_a - i_b;
			OP_AND: result = i_a & i_b;
			OP_OR: result = i_a | i_b;
			OP_XOR: result = i_a ^ i_b;
			OP_SLL: result = i_a << i_b[SH_W-1:0];
			OP_SRL: result = i_a >> i_b[SH_W-1:0];
			OP_ADDI: result = i_a + imm_sx;
			OP_LUI: result = {i_imm, {(XLEN-IMM_W){1'b0}}};
			default: result = '0;
		endcase
	end

	// nothing to write for r0
	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= i_valid && i_dest != '0;
		end
	end

	always_ff @(posedge clk) begin
		o_wb_addr <= i_dest;
		o_wb_data <= result;
	end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file
	import ooo_core_pkg::*;
(
	input  logic              clk,
	input  logic              i_we0,
	input  logic [REG_AW-1:0] i_waddr0,
	input  logic [XLEN-1:0]   i_wdata0,
	input  logic              i_we1,
	input  logic [REG_AW-1:0] i_waddr1,
	input  logic [XLEN-1:0]   i_wdata1,
	input  logic [REG_AW-1:0] i_raddr [2*WIN_SLOTS],
	output logic [XLEN-1:0]   o_rdata [2*WIN_SLOTS]
);

	logic [XLEN-1:0] regs [NREG];

	// r0 is never stored
	always_ff @(posedge clk) begin
		if (i_we0 && i_waddr0 != '0) begin
			regs[i_waddr0] <= i_wdata0;
		end
		if (i_we1 && i_waddr1 != '0) begin
			regs[i_waddr1] <= i_wdata1;
		end
	end

	// same-cycle write data bypasses the array
	always_comb begin
		for (int p = 0; p < 2*WIN_SLOTS; p++) begin
			if (i_raddr[p] == '0) begin
				o_rdata[p] = '0;
			end else if (i_we0 && i_waddr0 == i_raddr[p]) begin
				o_rdata[p] = i_wdata0;
			end else if (i_we1 && i_waddr1 == i_raddr[p]) begin
				o_rdata[p] = i_wdata1;
			end else begin
				o_rdata[p] = regs[i_raddr[p]];
			end
		end
	end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
	import ooo_core_pkg::*;
(
	input  logic [XLEN-1:0]   i_instr0,
	input  logic [XLEN-1:0]   i_instr1,
	input  logic              i_valid0,
	input  logic              i_valid1,
	output logic              o_valid [2],
	output opcode_t           o_opc [2],
	output logic [REG_AW-1:0] o_rd [2],
	output logic [REG_AW-1:0] o_rs [2],
	output logic [REG_AW-1:0] o_rt [2],
	output logic [IMM_W-1:0]  o_imm [2],
	output logic              o_has_dest [2]
);

	logic [XLEN-1:0] instr [2];

	assign instr[0] = i_instr0;
	assign instr[1] = i_instr1;
	assign o_valid[0] = i_valid0;
	assign o_valid[1] = i_valid1;

	// unknown codes fall back to nop
	function automatic opcode_t map_opc(input logic [OPC_W-1:0] raw);
		opcode_t opc;
		opc = opcode_t'(raw);
		case (opc)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_SLL, OP_SRL, OP_ADDI, OP_LUI: map_opc = opc;
			default: map_opc = OP_NOP;
		endcase
	endfunction

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			o_opc[k] = map_opc(instr[k][OPC_LSB +: OPC_W]);
			o_rd[k] = instr[k][RD_LSB +: REG_AW];
			o_rs[k] = instr[k][RS_LSB +: REG_AW];
			o_rt[k] = instr[k][RT_LSB +: REG_AW];
			o_imm[k] = instr[k][IMM_LSB +: IMM_W];
			// unused sources read r0 so they never block issue
			if (o_opc[k] == OP_LUI || o_opc[k] == OP_NOP) begin
				o_rs[k] = '0;
			end
			if (o_opc[k] inside {OP_ADDI, OP_LUI, OP_NOP}) begin
				o_rt[k] = '0;
			end
			o_has_dest[k] = (o_opc[k] != OP_NOP) && (o_rd[k] != '0);
		end
	end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
	import ooo_core_pkg::*;
#(
	parameter int PC_W = PC_W_DEFAULT
) (
	input  logic              clk,
	input  logic              rstn,
	input  logic              i_busy,
	output logic [PC_W-2:0]   o_imem_addr,
	input  logic [2*XLEN-1:0] i_imem_rdata,
	output logic [XLEN-1:0]   o_instr0,
	output logic [XLEN-1:0]   o_instr1,
	output logic              o_valid0,
	output logic              o_valid1
);

	logic [PC_W-1:0] pc;
	// pair now on the memory bus is valid
	logic f_valid;
	logic busy_q;
	logic skid_v;
	logic [XLEN-1:0] skid_instr0;
	logic [XLEN-1:0] skid_instr1;

	assign o_imem_addr = pc[PC_W-1:1];

	// both words of an aligned pair share one valid
	assign o_valid1 = o_valid0;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc <= '0;
			f_valid <= 1'b0;
			busy_q <= 1'b0;
			skid_v <= 1'b0;
			o_valid0 <= 1'b0;
		end else begin
			busy_q <= i_busy;
			f_valid <= 1'b1;
			if (!i_busy) begin
				pc <= {pc[PC_W-1:1] + 1'b1, 1'b0};
			end
			// first pair arriving under busy goes to the skid
			if (i_busy && !busy_q) begin
				skid_v <= f_valid;
			end
			if (!i_busy) begin
				o_valid0 <= busy_q ? skid_v : f_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_busy && !busy_q) begin
			skid_instr0 <= i_imem_rdata[2*XLEN-1:XLEN];
			skid_instr1 <= i_imem_rdata[XLEN-1:0];
		end
		// replay skid on the cycle busy drops
		if (!i_busy) begin
			o_instr0 <= busy_q ? skid_instr0 : i_imem_rdata[2*XLEN-1:XLEN];
			o_instr1 <= busy_q ? skid_instr1 : i_imem_rdata[XLEN-1:0];
		end
	end

endmodule

// File: hw/issue_window.sv
`timescale 1ns/1ps

module issue_window
	import ooo_core_pkg::*;
(
	input  logic              clk,
	input  logic              rstn,
	input  logic              i_valid [2],
	input  opcode_t           i_opc [2],
	input  logic [REG_AW-1:0] i_rd [2],
	input  logic [REG_AW-1:0] i_rs [2],
	input  logic [REG_AW-1:0] i_rt [2],
	input  logic [IMM_W-1:0]  i_imm [2],
	input  logic              i_has_dest [2],
	output logic              o_busy,
	output logic [REG_AW-1:0] o_rd_addr [2*WIN_SLOTS],
	input  logic [XLEN-1:0]   i_rd_data [2*WIN_SLOTS],
	output logic              o_iss0_valid,
	output opcode_t           o_iss0_opc,
	output logic [XLEN-1:0]   o_iss0_a,
	output logic [XLEN-1:0]   o_iss0_b,
	output logic [IMM_W-1:0]  o_iss0_imm,
	output logic [REG_AW-1:0] o_iss0_dest,
	output logic              o_iss1_valid,
	output opcode_t           o_iss1_opc,
	output logic [XLEN-1:0]   o_iss1_a,
	output logic [XLEN-1:0]   o_iss1_b,
	output logic [IMM_W-1:0]  o_iss1_imm,
	output logic [REG_AW-1:0] o_iss1_dest,
	input  logic              i_wb0_valid,
	input  logic [REG_AW-1:0] i_wb0_addr,
	input  logic              i_wb1_valid,
	input  logic [REG_AW-1:0] i_wb1_addr
);

	// slots ordered oldest first
	logic s_valid [WIN_SLOTS];
	opcode_t s_opc [WIN_SLOTS];
	logic [REG_AW-1:0] s_rd [WIN_SLOTS];
	logic [REG_AW-1:0] s_rs [WIN_SLOTS];
	logic [REG_AW-1:0] s_rt [WIN_SLOTS];
	logic [IMM_W-1:0] s_imm [WIN_SLOTS];

	logic n_valid [WIN_SLOTS];
	opcode_t n_opc [WIN_SLOTS];
	logic [REG_AW-1:0] n_rd [WIN_SLOTS];
	logic [REG_AW-1:0] n_rs [WIN_SLOTS];
	logic [REG_AW-1:0] n_rt [WIN_SLOTS];
	logic [IMM_W-1:0] n_imm [WIN_SLOTS];

	logic [NREG-1:0] board;
	logic [NREG-1:0] board_now;
	logic [NREG-1:0] clr_mask;
	logic [NREG-1:0] set_mask;
	logic [WIN_SLOTS-1:0] ready;
	logic [WIN_SLOTS-1:0] issued;
	logic [WIN_SLOTS-1:0] keep;
	logic sel_v [2];
	logic [1:0] sel_idx [2];

	always_comb begin
		for (int j = 0; j < WIN_SLOTS; j++) begin
			o_rd_addr[2*j] = s_rs[j];
			o_rd_addr[2*j+1] = s_rt[j];
		end
	end

	// write-backs this cycle are already visible through forwarding
	always_comb begin
		clr_mask = '0;
		if (i_wb0_valid) clr_mask[i_wb0_addr] = 1'b1;
		if (i_wb1_valid) clr_mask[i_wb1_addr] = 1'b1;
	end

	assign board_now = board & ~clr_mask;

	always_comb begin
		for (int j = 0; j < WIN_SLOTS; j++) begin
			ready[j] = s_valid[j] & ~board_now[s_rs[j]] & ~board_now[s_rt[j]]
				& ~board_now[s_rd[j]];
			for (int i = 0; i < j; i++) begin
				if (s_valid[i]) begin
					// raw on an older slot
					if (s_rd[i] != '0 && (s_rs[j] == s_rd[i] || s_rt[j] == s_rd[i]))
						ready[j] = 1'b0;
					// war and waw
					if (s_rd[j] != '0 && (s_rd[j] == s_rs[i] || s_rd[j] == s_rt[i]
						|| s_rd[j] == s_rd[i]))
						ready[j] = 1'b0;
				end
			end
		end
	end

	always_comb begin
		int n;
		n = 0;
		issued = '0;
		for (int u = 0; u < 2; u++) begin
			sel_v[u] = 1'b0;
			sel_idx[u] = '0;
		end
		for (int j = 0; j < WIN_SLOTS; j++) begin
			if (ready[j] && n < 2) begin
				sel_v[n] = 1'b1;
				sel_idx[n] = 2'(j);
				issued[j] = 1'b1;
				n++;
			end
		end
	end

	always_comb begin
		set_mask = '0;
		for (int u = 0; u < 2; u++) begin
			if (sel_v[u]) set_mask[s_rd[sel_idx[u]]] = 1'b1;
		end
		set_mask[0] = 1'b0;
	end

	always_comb begin
		for (int j = 0; j < WIN_SLOTS; j++) begin
			keep[j] = s_valid[j] & ~issued[j];
		end
	end

	// two or more left means busy
	assign o_busy = $countones(keep) >= 2;

	always_comb begin
		int n;
		n = 0;
		for (int j = 0; j < WIN_SLOTS; j++) begin
			n_valid[j] = 1'b0;
			n_opc[j] = OP_NOP;
			n_rd[j] = '0;
			n_rs[j] = '0;
			n_rt[j] = '0;
			n_imm[j] = '0;
		end
		for (int j = 0; j < WIN_SLOTS; j++) begin
			if (keep[j]) begin
				n_valid[n] = 1'b1;
				n_opc[n] = s_opc[j];
				n_rd[n] = s_rd[j];
				n_rs[n] = s_rs[j];
				n_rt[n] = s_rt[j];
				n_imm[n] = s_imm[j];
				n++;
			end
		end
		for (int k = 0; k < 2; k++) begin
			if (!o_busy && i_valid[k] && n < WIN_SLOTS) begin
				n_valid[n] = 1'b1;
				n_opc[n] = i_opc[k];
				n_rd[n] = i_has_dest[k] ? i_rd[k] : '0;
				n_rs[n] = i_rs[k];
				n_rt[n] = i_rt[k];
				n_imm[n] = i_imm[k];
				n++;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			board <= '0;
			o_iss0_valid <= 1'b0;
			o_iss1_valid <= 1'b0;
			for (int j = 0; j < WIN_SLOTS; j++) s_valid[j] <= 1'b0;
		end else begin
			board <= board_now | set_mask;
			o_iss0_valid <= sel_v[0];
			o_iss1_valid <= sel_v[1];
			for (int j = 0; j < WIN_SLOTS; j++) s_valid[j] <= n_valid[j];
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < WIN_SLOTS; j++) begin
			s_opc[j] <= n_opc[j];
			s_rd[j] <= n_rd[j];
			s_rs[j] <= n_rs[j];
			s_rt[j] <= n_rt[j];
			s_imm[j] <= n_imm[j];
		end
		o_iss0_opc <= s_opc[sel_idx[0]];
		o_iss0_a <= i_rd_data[2*sel_idx[0]];
		o_iss0_b <= i_rd_data[2*sel_idx[0]+1];
		o_iss0_imm <= s_imm[sel_idx[0]];
		o_iss0_dest <= s_rd[sel_idx[0]];
		o_iss1_opc <= s_opc[sel_idx[1]];
		o_iss1_a <= i_rd_data[2*sel_idx[1]];
		o_iss1_b <= i_rd_data[2*sel_idx[1]+1];
		o_iss1_imm <= s_imm[sel_idx[1]];
		o_iss1_dest <= s_rd[sel_idx[1]];
	end

endmodule

// File: hw/ooo_core.sv
`timescale 1ns/1ps

module ooo_core
	import ooo_core_pkg::*;
#(
	parameter int PC_W = PC_W_DEFAULT
) (
	input  logic              clk,
	input  logic              rstn,
	output logic [PC_W-2:0]   o_imem_addr,
	input  logic [2*XLEN-1:0] i_imem_rdata,
	output logic              o_wb0_valid,
	output logic [REG_AW-1:0] o_wb0_addr,
	output logic [XLEN-1:0]   o_wb0_data,
	output logic              o_wb1_valid,
	output logic [REG_AW-1:0] o_wb1_addr,
	output logic [XLEN-1:0]   o_wb1_data
);

	logic busy;
	logic [XLEN-1:0] f_instr0;
	logic [XLEN-1:0] f_instr1;
	logic f_valid0;
	logic f_valid1;

	logic d_valid [2];
	opcode_t d_opc [2];
	logic [REG_AW-1:0] d_rd [2];
	logic [REG_AW-1:0] d_rs [2];
	logic [REG_AW-1:0] d_rt [2];
	logic [IMM_W-1:0] d_imm [2];
	logic d_has_dest [2];

	logic [REG_AW-1:0] rd_addr [2*WIN_SLOTS];
	logic [XLEN-1:0] rd_data [2*WIN_SLOTS];

	logic iss0_valid;
	opcode_t iss0_opc;
	logic [XLEN-1:0] iss0_a;
	logic [XLEN-1:0] iss0_b;
	logic [IMM_W-1:0] iss0_imm;
	logic [REG_AW-1:0] iss0_dest;
	logic iss1_valid;
	opcode_t iss1_opc;
	logic [XLEN-1:0] iss1_a;
	logic [XLEN-1:0] iss1_b;
	logic [IMM_W-1:0] iss1_imm;
	logic [REG_AW-1:0] iss1_dest;

	fetch_stage #(
		.PC_W(PC_W)
	) u_fetch (
		.clk(clk),
		.rstn(rstn),
		.i_busy(busy),
		.o_imem_addr(o_imem_addr),
		.i_imem_rdata(i_imem_rdata),
		.o_instr0(f_instr0),
		.o_instr1(f_instr1),
		.o_valid0(f_valid0),
		.o_valid1(f_valid1)
	);

	decode_stage u_decode (
		.i_instr0(f_instr0),
		.i_instr1(f_instr1),
		.i_valid0(f_valid0),
		.i_valid1(f_valid1),
		.o_valid(d_valid),
		.o_opc(d_opc),
		.o_rd(d_rd),
		.o_rs(d_rs),
		.o_rt(d_rt),
		.o_imm(d_imm),
		.o_has_dest(d_has_dest)
	);

	issue_window u_window (
		.clk(clk),
		.rstn(rstn),
		.i_valid(d_valid),
		.i_opc(d_opc),
		.i_rd(d_rd),
		.i_rs(d_rs),
		.i_rt(d_rt),
		.i_imm(d_imm),
		.i_has_dest(d_has_dest),
		.o_busy(busy),
		.o_rd_addr(rd_addr),
		.i_rd_data(rd_data),
		.o_iss0_valid(iss0_valid),
		.o_iss0_opc(iss0_opc),
		.o_iss0_a(iss0_a),
		.o_iss0_b(iss0_b),
		.o_iss0_imm(iss0_imm),
		.o_iss0_dest(iss0_dest),
		.o_iss1_valid(iss1_valid),
		.o_iss1_opc(iss1_opc),
		.o_iss1_a(iss1_a),
		.o_iss1_b(iss1_b),
		.o_iss1_imm(iss1_imm),
		.o_iss1_dest(iss1_dest),
		.i_wb0_valid(o_wb0_valid),
		.i_wb0_addr(o_wb0_addr),
		.i_wb1_valid(o_wb1_valid),
		.i_wb1_addr(o_wb1_addr)
	);

	reg_file u_regs (
		.clk(clk),
		.i_we0(o_wb0_valid),
		.i_waddr0(o_wb0_addr),
		.i_wdata0(o_wb0_data),
		.i_we1(o_wb1_valid),
		.i_waddr1(o_wb1_addr),
		.i_wdata1(o_wb1_data),
		.i_raddr(rd_addr),
		.o_rdata(rd_data)
	);

	alu_unit u_alu0 (
		.clk(clk),
		.rstn(rstn),
		.i_valid(iss0_valid),
		.i_opc(iss0_opc),
		.i_a(iss0_a),
		.i_b(iss0_b),
		.i_imm(iss0_imm),
		.i_dest(iss0_dest),
		.o_wb_valid(o_wb0_valid),
		.o_wb_addr(o_wb0_addr),
		.o_wb_data(o_wb0_data)
	);

	alu_unit u_alu1 (
		.clk(clk),
		.rstn(rstn),
		.i_valid(iss1_valid),
		.i_opc(iss1_opc),
		.i_a(iss1_a),
		.i_b(iss1_b),
		.i_imm(iss1_imm),
		.i_dest(iss1_dest),
		.o_wb_valid(o_wb1_valid),
		.o_wb_addr(o_wb1_addr),
		.o_wb_data(o_wb1_data)
	);

endmodule

// File: verif/ooo_core_properties.sv
`timescale 1ns/1ps

module ooo_core_properties
	import ooo_core_pkg::*;
(
	input logic              clk,
	input logic              rstn,
	input logic              i_busy,
	input logic              i_wb0_valid,
	input logic [REG_AW-1:0] i_wb0_addr,
	input logic              i_wb1_valid,
	input logic [REG_AW-1:0] i_wb1_addr
);

	// window drains within a few write-back latencies
	localparam int BUSY_MAX = 16;

	logic [7:0] busy_run;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_run <= '0;
		end else if (i_busy) begin
			busy_run <= busy_run + 8'd1;
		end else begin
			busy_run <= '0;
		end
	end

	a_wb_addr_distinct: assert property (@(posedge clk) disable iff (!rstn)
		!(i_wb0_valid && i_wb1_valid && i_wb0_addr == i_wb1_addr))
		else $error("both write-back ports carry r%0d", i_wb0_addr);

	a_no_wb_in_reset: assert property (@(posedge clk) !rstn |=> !i_wb0_valid && !i_wb1_valid)
		else $error("write-back strobe while in reset");

	a_busy_bounded: assert property (@(posedge clk) disable iff (!rstn)
		busy_run < 8'(BUSY_MAX))
		else $error("busy held high for %0d cycles", busy_run);

endmodule

bind ooo_core ooo_core_properties i_props (
	.clk(clk),
	.rstn(rstn),
	.i_busy(busy),
	.i_wb0_valid(o_wb0_valid),
	.i_wb0_addr(o_wb0_addr),
	.i_wb1_valid(o_wb1_valid),
	.i_wb1_addr(o_wb1_addr)
);

// File: verif/ooo_core_model.svh
`ifndef OOO_CORE_MODEL_SVH
`define OOO_CORE_MODEL_SVH

// in-order model of the core over its own register array
// opcode sits in [31:26] with rd, rs and rt below it and imm in [15:0]

function automatic logic [XLEN-1:0] ref_result(input logic [XLEN-1:0] instr,
	input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
	logic [15:0] imm;
	imm = instr[15:0];
	case (instr[31:26])
		OP_ADD: return a + b;
		OP_SUB: return a - b;
		OP_AND: return a & b;
		OP_OR: return a | b;
		OP_XOR: return a ^ b;
		OP_SLL: return a << b[4:0];
		OP_SRL: return a >> b[4:0];
		OP_ADDI: return a + {{16{imm[15]}}, imm};
		OP_LUI: return {imm, 16'h0000};
		default: return '0;
	endcase
endfunction

// only known ops with a nonzero rd write anything
function automatic bit writes_reg(input logic [XLEN-1:0] instr);
	return instr[31:26] >= OP_ADD && instr[31:26] <= OP_LUI && instr[25:21] != 5'd0;
endfunction

task automatic build_expected();
	logic [XLEN-1:0] regs [NREG];
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] res;
	for (int r = 0; r < NREG; r++) begin
		regs[r] = '0;
		exp_q[r].delete();
	end
	n_expected = 0;
	foreach (prog[i]) begin
		instr = prog[i];
		res = ref_result(instr, regs[instr[20:16]], regs[instr[15:11]]);
		if (writes_reg(instr)) begin
			regs[instr[25:21]] = res;
			exp_q[instr[25:21]].push_back(res);
			n_expected++;
		end
	end
endtask

`endif

// File: verif/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb
	import ooo_core_pkg::*;
();

	localparam int PC_W = PC_W_DEFAULT;
	localparam int CLK_HALF = 50;
	localparam int TIMEOUT = 5000;

	logic clk = 1'b0;
	logic rstn = 1'b0;
	logic [PC_W-2:0] imem_addr;
	logic [2*XLEN-1:0] imem_rdata = '0;
	logic [PC_W-2:0] mem_addr_q = '0;
	logic wb0_valid;
	logic [REG_AW-1:0] wb0_addr;
	logic [XLEN-1:0] wb0_data;
	logic wb1_valid;
	logic [REG_AW-1:0] wb1_addr;
	logic [XLEN-1:0] wb1_data;

	logic [XLEN-1:0] prog [$];
	logic [XLEN-1:0] exp_q [NREG][$];
	int n_expected = 0;
	int n_seen = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int stall_cycles = 0;
	logic [PC_W-2:0] last_addr = '0;
	logic last_rstn = 1'b0;

	`include "ooo_core_model.svh"

	ooo_core #(
		.PC_W(PC_W)
	) i_ooo_core (
		.clk(clk),
		.rstn(rstn),
		.o_imem_addr(imem_addr),
		.i_imem_rdata(imem_rdata),
		.o_wb0_valid(wb0_valid),
		.o_wb0_addr(wb0_addr),
		.o_wb0_data(wb0_data),
		.o_wb1_valid(wb1_valid),
		.o_wb1_addr(wb1_addr),
		.o_wb1_data(wb1_data)
	);

	always #(CLK_HALF) clk = ~clk;

	// upper word is the even instruction and zeros fill past the program
	function automatic logic [2*XLEN-1:0] read_pair(input logic [PC_W-2:0] addr);
		int idx;
		logic [XLEN-1:0] w0;
		logic [XLEN-1:0] w1;
		idx = 2 * int'(addr);
		w0 = (idx < prog.size()) ? prog[idx] : '0;
		w1 = (idx + 1 < prog.size()) ? prog[idx + 1] : '0;
		return {w0, w1};
	endfunction

	always @(negedge clk) begin
		mem_addr_q = imem_addr;
	end

	always @(posedge clk) begin
		#1;
		imem_rdata = read_pair(mem_addr_q);
	end

	// a fetch address that did not move means the window held fetch
	always @(negedge clk) begin
		if (rstn && last_rstn && imem_addr == last_addr) begin
			stall_cycles++;
		end
		last_addr = imem_addr;
		last_rstn = rstn;
	end

	task automatic check_wb(input int port, input logic [REG_AW-1:0] addr,
		input logic [XLEN-1:0] data);
		bit have;
		logic [XLEN-1:0] exp;
		n_seen++;
		have = exp_q[addr].size() > 0;
		assert (have) else begin
			$display("%0t: unexpected write-back of r%0d on port %0d", $time, addr, port);
			test_errors++;
		end
		if (have) begin
			exp = exp_q[addr].pop_front();
			assert (data == exp) else begin
				$display("mismatch at %0t: port %0d r%0d is %h, expected %h",
					$time, port, addr, data, exp);
				test_errors++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (rstn) begin
			if (wb0_valid) check_wb(0, wb0_addr, wb0_data);
			if (wb1_valid) check_wb(1, wb1_addr, wb1_data);
			assert (!(wb0_valid && wb1_valid && wb0_addr == wb1_addr)) else begin
				$display("%0t: both ports wrote r%0d in one cycle", $time, wb0_addr);
				test_errors++;
			end
		end
	end

	function automatic logic [XLEN-1:0] encode(input logic [OPC_W-1:0] op, input int rd,
		input int rs, input int rt, input int imm);
		logic [XLEN-1:0] w;
		w = {op, rd[4:0], rs[4:0], imm[15:0]};
		if (op != OP_ADDI && op != OP_LUI) begin
			w[15:11] = rt[4:0];
		end
		return w;
	endfunction

	// one of the first n ops after nop
	function automatic logic [OPC_W-1:0] rand_op(input int n);
		return 6'(1 + $urandom_range(n - 1));
	endfunction

	function automatic int reg_or_zero();
		return ($urandom_range(1) == 0) ? 0 : 1 + $urandom_range(30);
	endfunction

	// every register gets a known value first
	task automatic load_regs();
		prog.delete();
		for (int r = 1; r < NREG; r++) begin
			prog.push_back(encode(OP_ADDI, r, 0, 0, $urandom));
		end
	endtask

	task automatic independent_ops();
		load_regs();
		repeat (40) begin
			prog.push_back(encode(rand_op(9), 16 + $urandom_range(15), 1 + $urandom_range(14),
				1 + $urandom_range(14), $urandom));
		end
	endtask

	task automatic dependent_chain();
		int prev;
		int rd;
		load_regs();
		prev = 1;
		repeat (40) begin
			rd = 1 + $urandom_range(30);
			prog.push_back(encode(rand_op(8), rd, prev, 1 + $urandom_range(30), $urandom));
			prev = rd;
		end
	endtask

	task automatic same_dest_writes();
		load_regs();
		repeat (24) begin
			prog.push_back(encode(rand_op(9), 7, ($urandom_range(1) == 0) ? 7 : 3, 12, $urandom));
		end
	endtask

	task automatic busy_mix();
		logic [OPC_W-1:0] op;
		load_regs();
		// few registers so most instructions depend on each other
		repeat (300) begin
			case ($urandom_range(15))
				0: op = OP_NOP;
				1: op = 6'h3f;
				default: op = rand_op(9);
			endcase
			prog.push_back(encode(op, $urandom_range(7), $urandom_range(7), $urandom_range(7),
				$urandom));
		end
	endtask

	task automatic zero_reg_ops();
		load_regs();
		repeat (40) begin
			prog.push_back(encode(rand_op(9), reg_or_zero(), reg_or_zero(), reg_or_zero(),
				$urandom));
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rstn = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rstn = 1'b1;
	endtask

	task automatic run_test(input string name, input bit want_stall);
		int cycles;
		test_errors = 0;
		n_seen = 0;
		build_expected();
		apply_reset();
		stall_cycles = 0;
		assert (imem_addr == '0) else begin
			$display("%0t: fetch address is %0d after reset instead of 0", $time, imem_addr);
			test_errors++;
		end
		// first write-back can come five cycles after reset release
		repeat (4) begin
			@(negedge clk);
			assert (!wb0_valid && !wb1_valid) else begin
				$display("%0t: write-back strobe before the first issue", $time);
				test_errors++;
			end
		end
		cycles = 0;
		while (n_seen < n_expected && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		assert (n_seen >= n_expected) else begin
			$display("%0t: timeout with %0d of %0d write-backs", $time, n_seen, n_expected);
			test_errors++;
		end
		// let fetch run past the program so late extra strobes show up
		cycles = 0;
		while (int'(imem_addr) < (prog.size() + 1) / 2 + 8 && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		assert (cycles < TIMEOUT) else begin
			$display("%0t: timeout, fetch never got past the program end", $time);
			test_errors++;
		end
		assert (n_seen == n_expected) else begin
			$display("%0t: %0d write-backs seen, %0d expected", $time, n_seen, n_expected);
			test_errors++;
		end
		if (want_stall) begin
			assert (stall_cycles > 0) else begin
				$display("%0t: fetch never stalled, so the window was never busy", $time);
				test_errors++;
			end
		end
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0) tests_failed++;
		$display("%s: %s, %0d instructions, %0d write-backs, %0d errors", name,
			(test_errors == 0) ? "passed" : "failed", prog.size(), n_seen, test_errors);
	endtask

	initial begin
		void'($urandom(32'ha0d57b9c));
		load_regs();
		run_test("after reset", 1'b0);
		independent_ops();
		run_test("independent ops", 1'b0);
		dependent_chain();
		run_test("dependent chain", 1'b0);
		same_dest_writes();
		run_test("same destination", 1'b0);
		busy_mix();
		run_test("busy mix", 1'b1);
		zero_reg_ops();
		run_test("register zero", 1'b0);
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+verif
hw/ooo_core_pkg.sv
hw/alu_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/fetch_stage.sv
hw/issue_window.sv
hw/ooo_core.sv
verif/ooo_core_properties.sv
verif/ooo_core_tb.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f build.f \
	&& ./obj_dir/Vooo_core_tb 2>&1 | tee sim.log

grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
